// ==== build.f ====
hw/awg_pkg.sv
hw/awg_host_regs.sv
hw/wave_ram.sv
hw/wave_sequencer.sv
hw/dac_out_stage.sv
hw/awg_top.sv
testbench/tb_awg_top.sv

// ==== hw/awg_host_regs.sv ====
`timescale 1ns/1ps

module awg_host_regs #(
   parameter int num_channels = 4
) (
   input  logic                    AD3542_CLK,
   input  logic                    arst_n,
   input  awg_pkg::host_wave_t     host_wave,
   input  logic                    ctrl_we,
   input  logic                    ctrl_word_sel,
   input  logic [31:0]             ctrl_wdata,
   input  logic                    cr_kick,
   output logic [num_channels-1:0] wave_we,
   output awg_pkg::wave_wr_t       wave_wr,
   output awg_pkg::seq_cfg_t       cfg,
   output logic                    kick
);

   import awg_pkg::*;

   logic                    cr_kick_d;
   logic [num_channels-1:0] wave_sel;

   // Channels at num_channels and above never match
   always_comb begin
      for (int i = 0; i < num_channels; i++) begin
         wave_sel[i] = host_wave.we && (host_wave.chan == chan_sel_t'(i));
      end
   end

   always_ff @(posedge AD3542_CLK or negedge arst_n) begin
      if (!arst_n) begin
         wave_we   <= '0;
         cr_kick_d <= 1'b0;
         kick      <= 1'b0;
      end else begin
         wave_we   <= wave_sel;
         cr_kick_d <= cr_kick;
         kick      <= cr_kick && !cr_kick_d;   // Rising edge only
      end
   end

   always_ff @(posedge AD3542_CLK) begin
      if (host_wave.we) begin
         wave_wr.addr <= host_wave.addr;
         wave_wr.data <= host_wave.data;
      end
   end

   // Lower word packs data_num and repetition, upper word is wait_num
   always_ff @(posedge AD3542_CLK or negedge arst_n) begin
      if (!arst_n) begin
         cfg <= '0;
      end else if (ctrl_we) begin
         if (ctrl_word_sel) begin
            cfg.wait_num <= ctrl_wdata;
         end else begin
            cfg.data_num   <= ctrl_wdata[wave_addr_w-1:0];
            cfg.repetition <= ctrl_wdata[wave_addr_w +: rep_w];
         end
      end
   end

   a_wave_we_onehot: assert property (
      @(posedge AD3542_CLK) disable iff (!arst_n)
      $onehot0(wave_we)
   );

endmodule

// ==== hw/awg_pkg.sv ====
package awg_pkg;

   localparam int wave_addr_w = 9;    // 512 samples per channel
   localparam int chan_sel_w  = 5;
   localparam int sample_w    = 16;   // DAC word
   localparam int rep_w       = 23;
   localparam int wait_w      = 32;

   typedef logic [wave_addr_w-1:0] wave_addr_t;
   typedef logic [chan_sel_w-1:0]  chan_sel_t;
   typedef logic [sample_w-1:0]    sample_word_t;
   typedef logic [rep_w-1:0]       rep_count_t;
   typedef logic [wait_w-1:0]      wait_count_t;   // In clock cycles

   // Host write into one channel's wave memory
   typedef struct packed {
      logic         we;
      chan_sel_t    chan;
      wave_addr_t   addr;
      sample_word_t data;
   } host_wave_t;

   typedef struct packed {
      wave_addr_t   addr;
      sample_word_t data;
   } wave_wr_t;   // Shared by all channels

   typedef struct packed {
      wave_addr_t  data_num;
      rep_count_t  repetition;
      wait_count_t wait_num;
   } seq_cfg_t;

   typedef struct packed {
      logic         valid;
      sample_word_t data;
   } sample_t;

   typedef enum logic [1:0] {
      seq_idle,
      seq_play,
      seq_wait
   } seq_state_t;

endpackage

// ==== hw/awg_top.sv ====
`timescale 1ns/1ps

module awg_top #(
   parameter int num_channels = 4
) (
   input  logic                    AD3542_CLK,
   input  logic                    arst_n,
   input  awg_pkg::host_wave_t     host_wave,
   input  logic                    ctrl_we,
   input  logic                    ctrl_word_sel,
   input  logic [31:0]             ctrl_wdata,
   input  logic                    cr_kick,
   input  logic                    cr_stop,
   input  logic                    sw_debug,
   input  logic [2:0]              sw_mode,
   output logic [num_channels-1:0] status,
   output awg_pkg::sample_word_t   dac_out [num_channels],
   output logic [num_channels-1:0] dac_update
);

   import awg_pkg::*;

   logic [num_channels-1:0] wave_we;
   wave_wr_t                wave_wr;
   seq_cfg_t                cfg;
   logic                    kick;
   sample_t                 samples [num_channels];

   awg_host_regs #(
      .num_channels (num_channels)
   ) i_host_regs (
      .AD3542_CLK    (AD3542_CLK),
      .arst_n        (arst_n),
      .host_wave     (host_wave),
      .ctrl_we       (ctrl_we),
      .ctrl_word_sel (ctrl_word_sel),
      .ctrl_wdata    (ctrl_wdata),
      .cr_kick       (cr_kick),
      .wave_we       (wave_we),
      .wave_wr       (wave_wr),
      .cfg           (cfg),
      .kick          (kick)
   );

   // One memory and one sequencer per DAC channel
   for (genvar ch = 0; ch < num_channels; ch++) begin : g_chan
      wave_addr_t   rd_addr;
      sample_word_t rd_data;

      wave_ram i_wave_ram (
         .AD3542_CLK (AD3542_CLK),
         .wr_en      (wave_we[ch]),
         .wr         (wave_wr),
         .rd_addr    (rd_addr),
         .rd_data    (rd_data)
      );

      wave_sequencer i_sequencer (
         .AD3542_CLK (AD3542_CLK),
         .arst_n     (arst_n),
         .cfg        (cfg),
         .kick       (kick),
         .stop       (cr_stop),   // Level shared by all channels
         .rd_addr    (rd_addr),
         .rd_data    (rd_data),
         .busy       (status[ch]),
         .sample     (samples[ch])
      );
   end

   dac_out_stage #(
      .num_channels (num_channels)
   ) i_dac_out (
      .AD3542_CLK (AD3542_CLK),
      .arst_n     (arst_n),
      .sample     (samples),
      .sw_debug   (sw_debug),
      .sw_mode    (sw_mode),
      .dac_out    (dac_out),
      .dac_update (dac_update)
   );

endmodule

// ==== hw/dac_out_stage.sv ====
`timescale 1ns/1ps

module dac_out_stage #(
   parameter int num_channels = 4
) (
   input  logic                    AD3542_CLK,
   input  logic                    arst_n,
   input  awg_pkg::sample_t        sample [num_channels],
   input  logic                    sw_debug,
   input  logic [2:0]              sw_mode,
   output awg_pkg::sample_word_t   dac_out [num_channels],
   output logic [num_channels-1:0] dac_update
);

   import awg_pkg::*;

   logic [3:0]   sw_meta;
   logic [3:0]   sw_sync;
   logic         debug_mode;
   logic [2:0]   test_mode;
   sample_word_t test_val;
   sample_word_t hold [num_channels];

   assign debug_mode = sw_sync[3];
   assign test_mode  = sw_sync[2:0];

   // Two flop synchronizer for the switches
   always_ff @(posedge AD3542_CLK or negedge arst_n) begin
      if (!arst_n) begin
         sw_meta <= '0;
         sw_sync <= '0;
      end else begin
         sw_meta <= {sw_debug, sw_mode};
         sw_sync <= sw_meta;
      end
   end

   always_ff @(posedge AD3542_CLK or negedge arst_n) begin
      if (!arst_n) begin
         test_val <= '0;
      end else begin
         case (test_mode)
            3'd1:    test_val <= 16'hFFFF;   // Full scale
            3'd2:    test_val <= 16'h7FFF;
            3'd3:    test_val <= 16'h0FFF;
            3'd4:    test_val <= 16'h07FF;
            3'd5:    test_val <= 16'h8000;   // Mid scale
            default: test_val <= 16'h0000;
         endcase
      end
   end

   always_ff @(posedge AD3542_CLK or negedge arst_n) begin
      if (!arst_n) begin
         dac_update <= '0;
         for (int i = 0; i < num_channels; i++) begin
            hold[i] <= '0;
         end
      end else begin
         for (int i = 0; i < num_channels; i++) begin
            dac_update[i] <= sample[i].valid;
            if (sample[i].valid) begin
               hold[i] <= sample[i].data;
            end
         end
      end
   end

   // Hold registers keep loading while the test value is shown
   always_comb begin
      for (int i = 0; i < num_channels; i++) begin
         dac_out[i] = debug_mode ? test_val : hold[i];
      end
   end

endmodule

// ==== hw/wave_ram.sv ====
`timescale 1ns/1ps

module wave_ram (
   input  logic                  AD3542_CLK,
   input  logic                  wr_en,
   input  awg_pkg::wave_wr_t     wr,
   input  awg_pkg::wave_addr_t   rd_addr,
   output awg_pkg::sample_word_t rd_data
);

   import awg_pkg::*;

   sample_word_t mem [2**wave_addr_w];   // Block RAM

   always_ff @(posedge AD3542_CLK) begin
      if (wr_en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // One cycle read latency
   always_ff @(posedge AD3542_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== hw/wave_sequencer.sv ====
`timescale 1ns/1ps

module wave_sequencer (
   input  logic                  AD3542_CLK,
   input  logic                  arst_n,
   input  awg_pkg::seq_cfg_t     cfg,
   input  logic                  kick,
   input  logic                  stop,
   output awg_pkg::wave_addr_t   rd_addr,
   input  awg_pkg::sample_word_t rd_data,
   output logic                  busy,
   output awg_pkg::sample_t      sample
);

   import awg_pkg::*;

   seq_state_t  state;
   wave_addr_t  addr_cnt;
   rep_count_t  pass_cnt;
   wait_count_t wait_cnt;
   logic        rd_vld;
   logic        start_ok;
   logic        last_addr;
   logic        last_pass;

   assign start_ok  = kick && !stop && (cfg.data_num != '0) && (cfg.repetition != '0);
   assign last_addr = (addr_cnt == wave_addr_t'(cfg.data_num - 1'b1));
   assign last_pass = (pass_cnt == rep_count_t'(cfg.repetition - 1'b1));

   always_ff @(posedge AD3542_CLK or negedge arst_n) begin
      if (!arst_n) begin
         state    <= seq_idle;
         addr_cnt <= '0;
         pass_cnt <= '0;
         wait_cnt <= '0;
         rd_vld   <= 1'b0;
      end else if (stop) begin
         state    <= seq_idle;   // Abort and drop the read in flight
         addr_cnt <= '0;
         rd_vld   <= 1'b0;
      end else begin
         rd_vld <= (state == seq_play);   // Tracks the RAM latency
         case (state)
            seq_idle: begin
               if (start_ok) begin
                  state    <= seq_play;
                  addr_cnt <= '0;
                  pass_cnt <= '0;
               end
            end
            seq_play: begin
               if (!last_addr) begin
                  addr_cnt <= addr_cnt + 1'b1;
               end else begin
                  addr_cnt <= '0;
                  if (last_pass) begin
                     state <= seq_idle;
                  end else if (cfg.wait_num == '0) begin
                     pass_cnt <= pass_cnt + 1'b1;   // Back to back passes
                  end else begin
                     state    <= seq_wait;
                     wait_cnt <= cfg.wait_num - 1'b1;
                  end
               end
            end
            seq_wait: begin
               if (wait_cnt == '0) begin
                  state    <= seq_play;
                  pass_cnt <= pass_cnt + 1'b1;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            default: begin
               state <= seq_idle;
            end
         endcase
      end
   end

   assign rd_addr = addr_cnt;

   // Last read of a run still counts as busy
   assign busy = (state != seq_idle) || rd_vld;

   assign sample.valid = rd_vld && !stop;
   assign sample.data  = rd_data;

   a_valid_busy: assert property (
      @(posedge AD3542_CLK) disable iff (!arst_n)
      sample.valid |-> busy
   );

   a_stop_idle: assert property (
      @(posedge AD3542_CLK) disable iff (!arst_n)
      stop |=> !busy
   );

endmodule

// ==== testbench/tb_awg_top.sv ====
`timescale 1ns/1ps

module tb_awg_top;

   import awg_pkg::*;

   localparam int n_chan     = 4;
   localparam int fill_words = 16;
   localparam int wait_limit = 2000;   // Cycles allowed per wait loop

   logic              AD3542_CLK;
   logic              arst_n;
   host_wave_t        host_wave;
   logic              ctrl_we;
   logic              ctrl_word_sel;
   logic [31:0]       ctrl_wdata;
   logic              cr_kick;
   logic              cr_stop;
   logic              sw_debug;
   logic [2:0]        sw_mode;
   logic [n_chan-1:0] status;
   sample_word_t      dac_out [n_chan];
   logic [n_chan-1:0] dac_update;

   logic [31:0]  lcg_state;
   sample_word_t exp_mem [n_chan][fill_words];   // Model of each wave memory

   awg_top #(
      .num_channels (n_chan)
   ) i_dut (
      .AD3542_CLK    (AD3542_CLK),
      .arst_n        (arst_n),
      .host_wave     (host_wave),
      .ctrl_we       (ctrl_we),
      .ctrl_word_sel (ctrl_word_sel),
      .ctrl_wdata    (ctrl_wdata),
      .cr_kick       (cr_kick),
      .cr_stop       (cr_stop),
      .sw_debug      (sw_debug),
      .sw_mode       (sw_mode),
      .status        (status),
      .dac_out       (dac_out),
      .dac_update    (dac_update)
   );

   always #10 AD3542_CLK = ~AD3542_CLK;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic sample_word_t mode_test_value(input logic [2:0] mode);
      case (mode)
         3'd1:    return 16'hFFFF;
         3'd2:    return 16'h7FFF;
         3'd3:    return 16'h0FFF;
         3'd4:    return 16'h07FF;
         3'd5:    return 16'h8000;
         default: return 16'h0000;
      endcase
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         abort_run($sformatf("[FAIL] %0t ns %s got %h expected %h",
                             $time, name, got, exp));
      end
   endtask

   task automatic write_wave(input int chan, input int addr, input sample_word_t data);
      @(negedge AD3542_CLK);
      host_wave.we   = 1'b1;
      host_wave.chan = chan_sel_t'(chan);
      host_wave.addr = wave_addr_t'(addr);
      host_wave.data = data;
      @(negedge AD3542_CLK);
      host_wave.we = 1'b0;
   endtask

   task automatic write_cfg(input int n_samp, input int n_rep, input int n_wait);
      @(negedge AD3542_CLK);
      ctrl_we       = 1'b1;
      ctrl_word_sel = 1'b0;
      ctrl_wdata    = {n_rep[22:0], n_samp[8:0]};   // repetition above data_num
      @(negedge AD3542_CLK);
      ctrl_word_sel = 1'b1;
      ctrl_wdata    = n_wait;
      @(negedge AD3542_CLK);
      ctrl_we = 1'b0;
   endtask

   task automatic pulse_kick();
      @(negedge AD3542_CLK);
      cr_kick = 1'b1;
      @(negedge AD3542_CLK);
      cr_kick = 1'b0;
   endtask

   task automatic check_quiet(input int n_cycles);
      repeat (n_cycles) begin
         @(negedge AD3542_CLK);
         check_value("status", status, '0);
         check_value("dac_update", dac_update, '0);
      end
   endtask

   task automatic expect_reset_state();
      check_value("status", status, '0);
      check_value("dac_update", dac_update, '0);
      for (int ch = 0; ch < n_chan; ch++) begin
         check_value($sformatf("dac_out[%0d]", ch), dac_out[ch], '0);
      end
   endtask

   task automatic fill_memories();
      logic [31:0] word;
      for (int ch = 0; ch < n_chan; ch++) begin
         for (int a = 0; a < fill_words; a++) begin
            word = lcg_next();
            exp_mem[ch][a] = word[31:16];   // Upper bits are the better ones
            write_wave(ch, a, word[31:16]);
         end
      end
   endtask

   // Kicks a run and checks every update against the memory model
   task automatic run_playback(input int n_samp, input int n_rep, input int n_wait);
      int   cnt [n_chan];
      int   gap;
      int   cyc;
      logic seen_busy;
      int   total;
      total     = n_samp * n_rep;
      gap       = 0;
      cyc       = 0;
      seen_busy = 1'b0;
      for (int ch = 0; ch < n_chan; ch++) begin
         cnt[ch] = 0;
      end
      write_cfg(n_samp, n_rep, n_wait);
      pulse_kick();
      while (!(seen_busy && status == '0)) begin
         @(negedge AD3542_CLK);
         cyc++;
         assert (cyc < wait_limit) else abort_run("Timeout waiting for playback to finish");
         if (status == '1) begin
            seen_busy = 1'b1;
         end
         for (int ch = 0; ch < n_chan; ch++) begin
            if (dac_update[ch]) begin
               assert (cnt[ch] < total) else
                  abort_run($sformatf("Channel %0d played more samples than configured", ch));
               check_value($sformatf("dac_out[%0d]", ch), dac_out[ch],
                           exp_mem[ch][cnt[ch] % n_samp]);
               cnt[ch]++;
            end
         end
         if (dac_update[0]) begin
            if (cnt[0] > 1 && (cnt[0] - 1) % n_samp == 0) begin   // First sample of a later pass
               assert (gap >= n_wait) else
                  abort_run($sformatf("Only %0d idle cycles between passes", gap));
            end
            gap = 0;
         end else begin
            gap++;
         end
      end
      repeat (3) begin
         @(negedge AD3542_CLK);
         check_value("dac_update", dac_update, '0);
      end
      for (int ch = 0; ch < n_chan; ch++) begin
         check_value($sformatf("update count ch%0d", ch), cnt[ch], total);
      end
   endtask

   task automatic reject_bad_channel();
      logic [31:0] word;
      for (int a = 0; a < 5; a++) begin
         word = lcg_next();
         write_wave(7, a, word[31:16]);   // No such channel
      end
      run_playback(5, 1, 10);
      write_cfg(0, 1, 0);
      pulse_kick();
      check_quiet(10);
   endtask

   task automatic stop_long_run();
      int cyc;
      write_cfg(8, 1000, 0);
      pulse_kick();
      cyc = 0;
      while (status != '1) begin
         @(negedge AD3542_CLK);
         cyc++;
         assert (cyc < wait_limit) else abort_run("Timeout waiting for busy after kick");
      end
      repeat (20) @(negedge AD3542_CLK);
      cr_stop = 1'b1;
      cyc = 0;
      do begin
         @(negedge AD3542_CLK);
         cyc++;
         assert (cyc <= 2) else abort_run("Status did not clear within 2 cycles of stop");
         check_value("dac_update", dac_update, '0);
      end while (status != '0);
      check_quiet(10);
      pulse_kick();   // Must be ignored while stop is high
      check_quiet(10);
      cr_stop = 1'b0;
      check_quiet(10);
   endtask

   task automatic sweep_debug_modes();
      run_playback(5, 1, 0);
      sw_debug = 1'b1;
      for (int m = 0; m < 8; m++) begin
         @(negedge AD3542_CLK);
         sw_mode = 3'(m);
         repeat (4) @(negedge AD3542_CLK);   // Sync plus registered table
         for (int ch = 0; ch < n_chan; ch++) begin
            check_value($sformatf("dac_out[%0d] mode %0d", ch, m), dac_out[ch],
                        mode_test_value(3'(m)));
         end
      end
      @(negedge AD3542_CLK);
      sw_debug = 1'b0;
      repeat (4) @(negedge AD3542_CLK);
      for (int ch = 0; ch < n_chan; ch++) begin
         check_value($sformatf("dac_out[%0d]", ch), dac_out[ch], exp_mem[ch][4]);
      end
   endtask

   initial begin
      #1ms;
      abort_run("Simulation watchdog expired before the tests completed");
   end

   initial begin
      AD3542_CLK    = 1'b0;
      arst_n        = 1'b0;
      host_wave     = '0;
      ctrl_we       = 1'b0;
      ctrl_word_sel = 1'b0;
      ctrl_wdata    = '0;
      cr_kick       = 1'b0;
      cr_stop       = 1'b0;
      sw_debug      = 1'b0;
      sw_mode       = '0;
      lcg_state     = 32'h98388680;
      repeat (4) @(posedge AD3542_CLK);
      @(negedge AD3542_CLK);
      arst_n = 1'b1;
      expect_reset_state();
      fill_memories();
      run_playback(5, 1, 0);
      run_playback(5, 3, 10);   // Three passes with a gap
      reject_bad_channel();
      stop_long_run();
      sweep_debug_modes();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
